// ==== common/ntm_defs.svh ====
// Size, fixed-point format and activation constants for the input gate datapath
`ifndef NTM_DEFS_SVH
`define NTM_DEFS_SVH

// Signed Q8.8 word
`define NTM_DATA_WIDTH 16
`define NTM_FRAC_BITS  8

// Gate vector length L and operand vector length N
`define NTM_SIZE_L 4
`define NTM_SIZE_N 4

// Matrix entry (l, n) sits at l*N + n
`define NTM_ADDR_WIDTH  4
`define NTM_INDEX_WIDTH 2

// Room for N full 32-bit products plus headroom
`define NTM_ACC_WIDTH 40

// Hard sigmoid, 0.5 + z/4 clamped to [0, 1] in Q8.8
`define NTM_SIG_HALF  128
`define NTM_SIG_ONE   256
`define NTM_SIG_SHIFT 2

`endif

// ==== common/ntm_pkg.sv ====
// Shared data, accumulator, operand-select and controller state types
`include "ntm_defs.svh"

package ntm_pkg;

  //////////////////////////////////////////////////////////////////////
  // Datapath words
  //////////////////////////////////////////////////////////////////////

  typedef logic signed [`NTM_DATA_WIDTH-1:0] data_t; // Q8.8
  typedef logic signed [`NTM_ACC_WIDTH-1:0]  acc_t;  // Full-precision dot product

  //////////////////////////////////////////////////////////////////////
  // Operand arrays
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    SEL_W = 3'd0, // Input weights, L x N
    SEL_K = 3'd1, // Read-vector weights, L x N
    SEL_U = 3'd2, // Recurrent weights, L x N
    SEL_X = 3'd3, // Controller input
    SEL_R = 3'd4, // Read vector
    SEL_H = 3'd5, // Previous hidden state
    SEL_B = 3'd6  // Bias, one per gate element
  } operand_sel_e;

  //////////////////////////////////////////////////////////////////////
  // Controller FSM
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,
    ST_PRODUCT  = 3'd1, // One MAC per column
    ST_RESULT   = 3'd2, // Row result latched, accumulator cleared
    ST_BIAS     = 3'd3,
    ST_LOGISTIC = 3'd4
  } gate_state_e;

endpackage

// ==== common/ntm_mac_if.sv ====
// Controller to matrix-product link: clear, enable, operand pair and row result
`timescale 1ns/10ps

interface ntm_mac_if;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  logic           clear;  // Latch row result, zero accumulator
  logic           enable; // Accumulate data_a * data_b this cycle
  ntm_pkg::data_t data_a; // Matrix entry
  ntm_pkg::data_t data_b; // Vector entry
  ntm_pkg::data_t result; // Scaled, saturated row sum

  //////////////////////////////////////////////////////////////////////
  // Views
  //////////////////////////////////////////////////////////////////////

  // Sequencer side
  modport ctrl (
    output clear,
    output enable,
    output data_a,
    output data_b,
    input  result
  );

  // Product engine side
  modport mac (
    input  clear,
    input  enable,
    input  data_a,
    input  data_b,
    output result
  );

endinterface

// ==== source/ntm_operand_store.sv ====
// Operand register file for W, K, U, x, r, h and b with host write and two read ports
`timescale 1ns/10ps
`include "ntm_defs.svh"

module ntm_operand_store (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          busy,     // Run in progress, host writes dropped
  input  logic                          wr_en,
  input  ntm_pkg::operand_sel_e         wr_sel,
  input  logic [`NTM_ADDR_WIDTH-1:0]    wr_addr,
  input  ntm_pkg::data_t                wr_data,
  input  ntm_pkg::operand_sel_e         mat_sel,  // W, K or U
  input  logic [`NTM_ADDR_WIDTH-1:0]    mat_addr,
  input  ntm_pkg::operand_sel_e         vec_sel,  // x, r, h or b
  input  logic [`NTM_INDEX_WIDTH-1:0]   vec_addr,
  output ntm_pkg::data_t                mat_data,
  output ntm_pkg::data_t                vec_data
);

  // Matrices flattened row-major
  ntm_pkg::data_t w_mem [0:`NTM_SIZE_L*`NTM_SIZE_N-1];
  ntm_pkg::data_t k_mem [0:`NTM_SIZE_L*`NTM_SIZE_N-1];
  ntm_pkg::data_t u_mem [0:`NTM_SIZE_L*`NTM_SIZE_N-1];
  ntm_pkg::data_t x_mem [0:`NTM_SIZE_N-1];
  ntm_pkg::data_t r_mem [0:`NTM_SIZE_N-1];
  ntm_pkg::data_t h_mem [0:`NTM_SIZE_N-1];
  ntm_pkg::data_t b_mem [0:`NTM_SIZE_L-1];

  logic                        wr_ok;    // Write accepted this edge
  logic [`NTM_INDEX_WIDTH-1:0] wr_index; // Vector slot

  assign wr_ok    = wr_en && !busy;
  assign wr_index = wr_addr[`NTM_INDEX_WIDTH-1:0];

  ///////////////////////////////////////////////////////////////////////
  // Host write
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      w_mem <= '{default: '0};
      k_mem <= '{default: '0};
      u_mem <= '{default: '0};
      x_mem <= '{default: '0};
      r_mem <= '{default: '0};
      h_mem <= '{default: '0};
      b_mem <= '{default: '0};
    end else if (wr_ok) begin
      case (wr_sel)
        ntm_pkg::SEL_W: w_mem[wr_addr]  <= wr_data;
        ntm_pkg::SEL_K: k_mem[wr_addr]  <= wr_data;
        ntm_pkg::SEL_U: u_mem[wr_addr]  <= wr_data;
        ntm_pkg::SEL_X: x_mem[wr_index] <= wr_data;
        ntm_pkg::SEL_R: r_mem[wr_index] <= wr_data;
        ntm_pkg::SEL_H: h_mem[wr_index] <= wr_data;
        ntm_pkg::SEL_B: b_mem[wr_index] <= wr_data;
        default: ; // Unused code, nothing written
      endcase
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Read ports, combinational
  ///////////////////////////////////////////////////////////////////////

  always_comb begin
    case (mat_sel)
      ntm_pkg::SEL_W: mat_data = w_mem[mat_addr];
      ntm_pkg::SEL_K: mat_data = k_mem[mat_addr];
      ntm_pkg::SEL_U: mat_data = u_mem[mat_addr];
      default:        mat_data = '0;
    endcase
  end

  always_comb begin
    case (vec_sel)
      ntm_pkg::SEL_X: vec_data = x_mem[vec_addr];
      ntm_pkg::SEL_R: vec_data = r_mem[vec_addr];
      ntm_pkg::SEL_H: vec_data = h_mem[vec_addr];
      ntm_pkg::SEL_B: vec_data = b_mem[vec_addr];
      default:        vec_data = '0;
    endcase
  end

  // Host must keep vector writes inside the N slots; upper address bits are not decoded
  a_vec_addr_range: assert property (@(posedge CLK) disable iff (RST)
    (wr_ok && wr_sel inside {ntm_pkg::SEL_X, ntm_pkg::SEL_R, ntm_pkg::SEL_H, ntm_pkg::SEL_B})
      |-> (wr_addr < `NTM_SIZE_N));

endmodule

// ==== matrix_product/ntm_matrix_product.sv ====
// Multiply-accumulate row engine with Q8.8 rescale and 16-bit saturation
`timescale 1ns/10ps
`include "ntm_defs.svh"

module ntm_matrix_product (
  input logic   CLK,
  input logic   RST,
  ntm_mac_if.mac mac
);

  ///////////////////////////////////////////////////////////////////////
  // Constants
  ///////////////////////////////////////////////////////////////////////

  // Word limits held at accumulator width for the compare
  localparam ntm_pkg::acc_t MAX_WORD = 2**(`NTM_DATA_WIDTH-1) - 1;
  localparam ntm_pkg::acc_t MIN_WORD = -(2**(`NTM_DATA_WIDTH-1));

  ///////////////////////////////////////////////////////////////////////
  // Signals
  ///////////////////////////////////////////////////////////////////////

  ntm_pkg::acc_t  acc;      // Running row sum, Q16.16
  ntm_pkg::acc_t  product;  // Current term, sign-extended
  ntm_pkg::acc_t  shifted;  // Back to Q8.8 scale
  ntm_pkg::data_t sat_word; // Clipped to one word

  ///////////////////////////////////////////////////////////////////////
  // Body
  ///////////////////////////////////////////////////////////////////////

  // 16x16 signed, widened before the add
  assign product = ntm_pkg::acc_t'(mac.data_a * mac.data_b);
  assign shifted = acc >>> `NTM_FRAC_BITS; // Arithmetic, keeps sign

  always_comb begin
    if (shifted > MAX_WORD) begin
      sat_word = MAX_WORD[`NTM_DATA_WIDTH-1:0];
    end else if (shifted < MIN_WORD) begin
      sat_word = MIN_WORD[`NTM_DATA_WIDTH-1:0];
    end else begin
      sat_word = shifted[`NTM_DATA_WIDTH-1:0];
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc        <= '0;
      mac.result <= '0;
    end else if (mac.clear) begin
      mac.result <= sat_word; // Valid from next cycle on
      acc        <= '0;       // Ready for next row
    end else if (mac.enable) begin
      acc <= acc + product;
    end
  end

  // Sequencer keeps clear and enable apart, else a term would be lost
  a_clear_enable_excl: assert property (@(posedge CLK) disable iff (RST)
    !(mac.clear && mac.enable));

endmodule

// ==== source/ntm_vector_logistic.sv ====
// Registered hard-sigmoid stage, 0.5 + z/4 clamped to [0, 1], with index pass-through
`timescale 1ns/10ps
`include "ntm_defs.svh"

module ntm_vector_logistic (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        valid_in,
  input  ntm_pkg::data_t              z_in,      // Pre-activation, Q8.8
  input  logic [`NTM_INDEX_WIDTH-1:0] index_in,
  output logic                        valid_out,
  output ntm_pkg::data_t              y_out,     // Gate value, 0 .. 1.0
  output logic [`NTM_INDEX_WIDTH-1:0] index_out
);

  ///////////////////////////////////////////////////////////////////////
  // Hard sigmoid
  ///////////////////////////////////////////////////////////////////////

  ntm_pkg::data_t                   z_quarter; // z / 4
  logic signed [`NTM_DATA_WIDTH:0]  biased;    // One extra bit, never wraps
  ntm_pkg::data_t                   y_next;

  assign z_quarter = z_in >>> `NTM_SIG_SHIFT;
  assign biased    = `NTM_SIG_HALF + z_quarter;

  // Clamp to [0, 1.0]
  always_comb begin
    if (biased < 0) begin
      y_next = '0;
    end else if (biased > `NTM_SIG_ONE) begin
      y_next = `NTM_SIG_ONE;
    end else begin
      y_next = biased[`NTM_DATA_WIDTH-1:0];
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Output register
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_in; // One-cycle strobe
    end
  end

  // Value and index only move with a valid input
  always_ff @(posedge CLK) begin
    if (valid_in) begin
      y_out     <= y_next;
      index_out <= index_in;
    end
  end

endmodule

// ==== source/ntm_input_gate_vector.sv ====
// Input gate sequencer FSM: three row products, saturating sum, bias add and hand-off
`timescale 1ns/10ps
`include "ntm_defs.svh"

module ntm_input_gate_vector (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  ntm_mac_if.ctrl                     mac,
  input  ntm_pkg::data_t              mat_data,
  input  ntm_pkg::data_t              vec_data,
  output logic                        ready,    // One pulse after the last element
  output logic                        busy,
  output ntm_pkg::operand_sel_e       mat_sel,
  output logic [`NTM_ADDR_WIDTH-1:0]  mat_addr,
  output ntm_pkg::operand_sel_e       vec_sel,
  output logic [`NTM_INDEX_WIDTH-1:0] vec_addr,
  output logic                        z_valid,
  output ntm_pkg::data_t              z_out,
  output logic [`NTM_INDEX_WIDTH-1:0] z_index
);

  ///////////////////////////////////////////////////////////////////////
  // Signals
  ///////////////////////////////////////////////////////////////////////

  ntm_pkg::gate_state_e        state;
  logic [`NTM_INDEX_WIDTH-1:0] element;   // Gate row l
  logic [`NTM_INDEX_WIDTH-1:0] column;    // Term n within the row
  logic [1:0]                  product;   // 0 W.x, 1 K.r, 2 U.h
  logic                        last_done; // Final element left the FSM
  ntm_pkg::data_t              sum;       // Running pre-activation
  ntm_pkg::data_t              z_next;

  // Two's-complement add clipped to one word
  function automatic ntm_pkg::data_t sat_add(input ntm_pkg::data_t a,
                                             input ntm_pkg::data_t b);
    logic signed [`NTM_DATA_WIDTH:0] s;
    s = a + b;
    if (s[`NTM_DATA_WIDTH] != s[`NTM_DATA_WIDTH-1]) begin
      // Overflow, pick the limit by true sign
      return s[`NTM_DATA_WIDTH] ? {1'b1, {(`NTM_DATA_WIDTH-1){1'b0}}}
                                : {1'b0, {(`NTM_DATA_WIDTH-1){1'b1}}};
    end
    return s[`NTM_DATA_WIDTH-1:0];
  endfunction

  ///////////////////////////////////////////////////////////////////////
  // Operand addressing and MAC drive
  ///////////////////////////////////////////////////////////////////////

  always_comb begin
    case (product)
      2'd0: begin
        mat_sel = ntm_pkg::SEL_W;
        vec_sel = ntm_pkg::SEL_X;
      end
      2'd1: begin
        mat_sel = ntm_pkg::SEL_K;
        vec_sel = ntm_pkg::SEL_R;
      end
      default: begin
        mat_sel = ntm_pkg::SEL_U;
        vec_sel = ntm_pkg::SEL_H;
      end
    endcase
    vec_addr = column;
    if (state == ntm_pkg::ST_BIAS) begin // Bias is indexed by row
      vec_sel  = ntm_pkg::SEL_B;
      vec_addr = element;
    end
  end

  assign mat_addr   = {element, column}; // l*N + n
  assign mac.enable = (state == ntm_pkg::ST_PRODUCT);
  assign mac.clear  = (state == ntm_pkg::ST_RESULT);
  assign mac.data_a = mat_data;
  assign mac.data_b = vec_data;

  // Busy until ready goes out, so no restart overlaps it
  assign busy = (state != ntm_pkg::ST_IDLE) || last_done;

  // ((W.x + K.r) + U.h) + b, each step saturating
  assign z_next = sat_add(sat_add(sum, mac.result), vec_data);

  ///////////////////////////////////////////////////////////////////////
  // FSM
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ntm_pkg::ST_IDLE;
      element   <= '0;
      column    <= '0;
      product   <= '0;
      last_done <= 1'b0;
      ready     <= 1'b0;
      z_valid   <= 1'b0;
    end else begin
      z_valid   <= 1'b0;
      last_done <= 1'b0;
      ready     <= last_done;
      case (state)
        ntm_pkg::ST_IDLE: begin
          if (start && !last_done) begin
            state   <= ntm_pkg::ST_PRODUCT;
            element <= '0;
            column  <= '0;
            product <= '0;
          end
        end
        ntm_pkg::ST_PRODUCT: begin
          column <= column + 1'b1; // Wraps to 0 after N-1
          if (column == `NTM_SIZE_N-1) state <= ntm_pkg::ST_RESULT;
        end
        ntm_pkg::ST_RESULT: begin
          if (product == 2'd2) begin
            state <= ntm_pkg::ST_BIAS;
          end else begin
            product <= product + 1'b1;
            state   <= ntm_pkg::ST_PRODUCT;
          end
        end
        ntm_pkg::ST_BIAS: begin
          z_valid <= 1'b1; // Logistic samples during ST_LOGISTIC
          state   <= ntm_pkg::ST_LOGISTIC;
        end
        ntm_pkg::ST_LOGISTIC: begin
          if (element == `NTM_SIZE_L-1) begin
            last_done <= 1'b1;
            state     <= ntm_pkg::ST_IDLE;
          end else begin
            element <= element + 1'b1;
            product <= '0;
            state   <= ntm_pkg::ST_PRODUCT;
          end
        end
        default: state <= ntm_pkg::ST_IDLE;
      endcase
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Running sum
  ///////////////////////////////////////////////////////////////////////

  // Previous row result is valid on the first column of the next product
  always_ff @(posedge CLK) begin
    if (state == ntm_pkg::ST_PRODUCT && column == '0 && product != 2'd0) begin
      sum <= (product == 2'd1) ? mac.result : sat_add(sum, mac.result);
    end
    if (state == ntm_pkg::ST_BIAS) begin
      z_out   <= z_next;
      z_index <= element;
    end
  end

  // Completion must not be flagged while a run still holds the datapath
  a_ready_not_busy: assert property (@(posedge CLK) disable iff (RST)
    $rose(ready) |-> !busy);

endmodule

// ==== source/ntm_input_gate_top.sv ====
// Input gate top: operand store, sequencer, MAC row engine and hard-sigmoid stage
`timescale 1ns/10ps
`include "ntm_defs.svh"

module ntm_input_gate_top (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  input  logic                        wr_en,
  input  ntm_pkg::operand_sel_e       wr_sel,
  input  logic [`NTM_ADDR_WIDTH-1:0]  wr_addr,
  input  ntm_pkg::data_t              wr_data,
  output logic                        ready,
  output logic                        i_out_enable,
  output logic [`NTM_INDEX_WIDTH-1:0] i_out_index,
  output ntm_pkg::data_t              i_out
);

  ///////////////////////////////////////////////////////////////////////
  // Internal wiring
  ///////////////////////////////////////////////////////////////////////

  logic                        busy;
  ntm_pkg::operand_sel_e       mat_sel;
  logic [`NTM_ADDR_WIDTH-1:0]  mat_addr;
  ntm_pkg::data_t              mat_data;
  ntm_pkg::operand_sel_e       vec_sel;
  logic [`NTM_INDEX_WIDTH-1:0] vec_addr;
  ntm_pkg::data_t              vec_data;
  logic                        z_valid;   // Pre-activation hand-off
  ntm_pkg::data_t              z_out;
  logic [`NTM_INDEX_WIDTH-1:0] z_index;

  ntm_mac_if mac_if ();

  ///////////////////////////////////////////////////////////////////////
  // Blocks
  ///////////////////////////////////////////////////////////////////////

  ntm_operand_store i_ntm_operand_store (
    .CLK, .RST, .busy, .wr_en, .wr_sel, .wr_addr, .wr_data,
    .mat_sel, .mat_addr, .vec_sel, .vec_addr, .mat_data, .vec_data
  );

  ntm_input_gate_vector i_ntm_input_gate_vector (
    .CLK, .RST, .start, .mac(mac_if.ctrl), .mat_data, .vec_data,
    .ready, .busy, .mat_sel, .mat_addr, .vec_sel, .vec_addr,
    .z_valid, .z_out, .z_index
  );

  ntm_matrix_product i_ntm_matrix_product (
    .CLK, .RST, .mac(mac_if.mac)
  );

  // Output strobe comes straight from the activation register
  ntm_vector_logistic i_ntm_vector_logistic (
    .CLK, .RST, .valid_in(z_valid), .z_in(z_out), .index_in(z_index),
    .valid_out(i_out_enable), .y_out(i_out), .index_out(i_out_index)
  );

endmodule

// ==== test/ntm_input_gate_model.svh ====
// Reference model of the gate arithmetic, operand set and stimulus table row types
`ifndef NTM_INPUT_GATE_MODEL_SVH
`define NTM_INPUT_GATE_MODEL_SVH

`include "ntm_defs.svh"

typedef enum {MODE_ZERO, MODE_SMALL, MODE_POS, MODE_NEG} operand_mode_e;

// One table entry
typedef struct {
  string         name;
  operand_mode_e mode;
  bit            start_busy; // Second start during the run
  bit            write_busy; // Operand writes during the run
} test_row_t;

// Full operand image as the host loads it
typedef struct packed {
  logic [`NTM_SIZE_L*`NTM_SIZE_N-1:0][`NTM_DATA_WIDTH-1:0] w;
  logic [`NTM_SIZE_L*`NTM_SIZE_N-1:0][`NTM_DATA_WIDTH-1:0] k;
  logic [`NTM_SIZE_L*`NTM_SIZE_N-1:0][`NTM_DATA_WIDTH-1:0] u;
  logic [`NTM_SIZE_N-1:0][`NTM_DATA_WIDTH-1:0]             x;
  logic [`NTM_SIZE_N-1:0][`NTM_DATA_WIDTH-1:0]             r;
  logic [`NTM_SIZE_N-1:0][`NTM_DATA_WIDTH-1:0]             h;
  logic [`NTM_SIZE_L-1:0][`NTM_DATA_WIDTH-1:0]             b;
} operand_set_t;

// Limit to a signed 16-bit word
function automatic longint clip_word(input longint v);
  if (v > 32767) return 32767;
  if (v < -32768) return -32768;
  return v;
endfunction

// Row l of W.x (0), K.r (1) or U.h (2), rescaled from Q16.16
function automatic longint row_term(input operand_set_t ops, input int which, input int l);
  longint acc;
  longint a;
  longint v;
  int     n;
  acc = 0;
  for (n = 0; n < `NTM_SIZE_N; n++) begin
    case (which)
      0:       begin a = $signed(ops.w[l*`NTM_SIZE_N+n]); v = $signed(ops.x[n]); end
      1:       begin a = $signed(ops.k[l*`NTM_SIZE_N+n]); v = $signed(ops.r[n]); end
      default: begin a = $signed(ops.u[l*`NTM_SIZE_N+n]); v = $signed(ops.h[n]); end
    endcase
    acc = acc + a * v;
  end
  return clip_word(acc >>> 8);
endfunction

// Expected gate value i(l) in Q8.8
function automatic longint gate_expected(input operand_set_t ops, input int l);
  longint z;
  longint bias;
  longint y;
  bias = $signed(ops.b[l]);
  z = clip_word(row_term(ops, 0, l) + row_term(ops, 1, l));
  z = clip_word(z + row_term(ops, 2, l));
  z = clip_word(z + bias);
  y = 128 + (z >>> 2); // 0.5 + z/4
  if (y < 0) y = 0;
  else if (y > 256) y = 256;
  return y;
endfunction

`endif

// ==== test/ntm_input_gate_tb.sv ====
// Testbench for the input gate top: table-driven runs, busy-time pokes and model checks
`timescale 1ns/10ps
`include "ntm_defs.svh"
`include "ntm_input_gate_model.svh"

module ntm_input_gate_tb;

  localparam int TIMEOUT_CYCLES = 200; // Per wait, a full run is 69
  localparam int NUM_ROWS       = 6;

  logic                        CLK;
  logic                        RST;
  logic                        start;
  logic                        wr_en;
  ntm_pkg::operand_sel_e       wr_sel;
  logic [`NTM_ADDR_WIDTH-1:0]  wr_addr;
  ntm_pkg::data_t              wr_data;
  logic                        ready;
  logic                        i_out_enable;
  logic [`NTM_INDEX_WIDTH-1:0] i_out_index;
  ntm_pkg::data_t              i_out;

  test_row_t           table_rows [NUM_ROWS];
  logic signed [63:0]  got_val [`NTM_SIZE_L];
  logic signed [63:0]  got_idx [`NTM_SIZE_L];
  int                  strobe_count; // Since reset
  int                  ready_count;
  int                  error_count;
  int                  fail_tests;
  int                  run_tests;
  bit                  timed_out;    // Some wait gave up

  ntm_input_gate_top i_ntm_input_gate_top (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Pulse counters, updated after the edge so readers at the edge see stable values
  always @(posedge CLK or posedge RST) begin
    if (RST) begin
      strobe_count <= 0;
      ready_count  <= 0;
    end else begin
      if (i_out_enable === 1'b1) strobe_count <= strobe_count + 1;
      if (ready === 1'b1) ready_count <= ready_count + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string what, input logic signed [63:0] got,
                               input logic signed [63:0] expected);
    if (got !== expected) begin
      error_count++;
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  task automatic report_timeout(input string what, input string test_name);
    timed_out = 1'b1;
    $display("Timeout: no %s within %0d cycles in test %s", what, TIMEOUT_CYCLES, test_name);
  endtask

  function automatic logic [15:0] pick_word(input operand_mode_e mode, input bit is_matrix);
    case (mode)
      MODE_ZERO:  return 16'h0000;
      MODE_SMALL: return 16'(int'($urandom % 384) - 192); // About +-0.75
      MODE_POS:   return 16'h7fff;
      default:    return is_matrix ? 16'h7fff : 16'h8000; // Negative products
    endcase
  endfunction

  function automatic operand_set_t make_operands(input operand_mode_e mode);
    operand_set_t ops;
    int           i;
    ops = '0;
    for (i = 0; i < `NTM_SIZE_L*`NTM_SIZE_N; i++) begin
      ops.w[i] = pick_word(mode, 1'b1);
      ops.k[i] = pick_word(mode, 1'b1);
      ops.u[i] = pick_word(mode, 1'b1);
    end
    for (i = 0; i < `NTM_SIZE_N; i++) begin
      ops.x[i] = pick_word(mode, 1'b0);
      ops.r[i] = pick_word(mode, 1'b0);
      ops.h[i] = pick_word(mode, 1'b0);
      ops.b[i] = pick_word(mode, 1'b0);
    end
    return ops;
  endfunction

  task automatic write_word(input ntm_pkg::operand_sel_e sel, input int addr,
                            input logic [15:0] data);
    @(posedge CLK);
    wr_en   <= 1'b1;
    wr_sel  <= sel;
    wr_addr <= 4'(addr);
    wr_data <= data;
  endtask

  task automatic end_writes();
    @(posedge CLK);
    wr_en <= 1'b0;
  endtask

  task automatic load_operands(input operand_set_t ops);
    int i;
    for (i = 0; i < `NTM_SIZE_L*`NTM_SIZE_N; i++) begin
      write_word(ntm_pkg::SEL_W, i, ops.w[i]);
      write_word(ntm_pkg::SEL_K, i, ops.k[i]);
      write_word(ntm_pkg::SEL_U, i, ops.u[i]);
    end
    for (i = 0; i < `NTM_SIZE_N; i++) begin
      write_word(ntm_pkg::SEL_X, i, ops.x[i]);
      write_word(ntm_pkg::SEL_R, i, ops.r[i]);
      write_word(ntm_pkg::SEL_H, i, ops.h[i]);
      write_word(ntm_pkg::SEL_B, i, ops.b[i]);
    end
    end_writes();
  endtask

  task automatic pulse_start();
    @(posedge CLK);
    start <= 1'b1;
    @(posedge CLK);
    start <= 1'b0;
  endtask

  task automatic wait_for_strobe(input int slot, input string test_name);
    int cycles;
    cycles = 0;
    @(posedge CLK);
    while (i_out_enable !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycles++;
    end
    if (i_out_enable !== 1'b1) begin
      report_timeout("output strobe", test_name);
    end else begin
      got_val[slot] = i_out;
      got_idx[slot] = {1'b0, i_out_index};
    end
  endtask

  task automatic wait_for_ready(input string test_name);
    int cycles;
    cycles = 0;
    @(posedge CLK);
    while (ready !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycles++;
    end
    if (ready !== 1'b1) report_timeout("ready pulse", test_name);
  endtask

  //////////////////////////////////////////////////////////////////////
  // One table row
  //////////////////////////////////////////////////////////////////////

  task automatic run_row(input int t);
    operand_set_t ops;
    int           errors_before;
    int           base_strobes;
    int           base_ready;
    int           l;
    errors_before = error_count;
    ops = make_operands(table_rows[t].mode);
    load_operands(ops);
    if (t == 0) begin // Nothing may come out before the first start
      compare_value("strobes before first start", strobe_count, 0);
      compare_value("ready pulses before first start", ready_count, 0);
    end
    base_strobes = strobe_count;
    base_ready   = ready_count;
    pulse_start();
    if (table_rows[t].write_busy) begin
      write_word(ntm_pkg::SEL_B, 0, 16'h7000); // Dropped, model keeps old operands
      write_word(ntm_pkg::SEL_X, 0, 16'h7fff);
      end_writes();
    end
    if (table_rows[t].start_busy) pulse_start();
    for (l = 0; l < `NTM_SIZE_L && !timed_out; l++) begin
      if (table_rows[t].start_busy && l == `NTM_SIZE_L-1) begin
        start <= 1'b1; // Held over the last element and the cycle after its strobe
      end
      wait_for_strobe(l, table_rows[t].name);
    end
    start <= 1'b0;
    if (!timed_out) wait_for_ready(table_rows[t].name);
    if (!timed_out) begin
      if (table_rows[t].start_busy) begin
        repeat (80) @(posedge CLK); // Long enough to see a second run begin
      end else begin
        @(posedge CLK);
      end
      compare_value("strobe count", strobe_count - base_strobes, `NTM_SIZE_L);
      compare_value("ready count", ready_count - base_ready, 1);
      for (l = 0; l < `NTM_SIZE_L; l++) begin
        compare_value($sformatf("index of strobe %0d", l), got_idx[l], l);
        compare_value($sformatf("gate %0d", l), got_val[l], gate_expected(ops, l));
      end
    end
    run_tests++;
    if (error_count != errors_before || timed_out) fail_tests++;
    $display("Test %-14s %s", table_rows[t].name,
             (error_count == errors_before && !timed_out) ? "pass" : "FAIL");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int t;
    int errors_before;
    void'($urandom(32'h57f2923a));
    RST     = 1'b1;
    start   = 1'b0;
    wr_en   = 1'b0;
    wr_sel  = ntm_pkg::SEL_W;
    wr_addr = '0;
    wr_data = '0;
    error_count = 0;
    fail_tests  = 0;
    run_tests   = 0;
    timed_out   = 1'b0;
    table_rows[0] = '{"all_zero",    MODE_ZERO,  1'b0, 1'b0};
    table_rows[1] = '{"small_rand",  MODE_SMALL, 1'b0, 1'b0};
    table_rows[2] = '{"write_busy",  MODE_SMALL, 1'b0, 1'b1};
    table_rows[3] = '{"start_busy",  MODE_SMALL, 1'b1, 1'b0};
    table_rows[4] = '{"large_pos",   MODE_POS,   1'b0, 1'b0};
    table_rows[5] = '{"large_neg",   MODE_NEG,   1'b0, 1'b0};
    repeat (5) @(posedge CLK);
    RST <= 1'b0;
    // Quiet outputs after reset
    errors_before = error_count;
    repeat (8) begin
      @(posedge CLK);
      compare_value("ready after reset", ready, 0);
      compare_value("i_out_enable after reset", i_out_enable, 0);
    end
    run_tests++;
    if (error_count != errors_before) fail_tests++;
    $display("Test %-14s %s", "reset_idle", (error_count == errors_before) ? "pass" : "FAIL");
    for (t = 0; t < NUM_ROWS && !timed_out; t++) begin
      run_row(t);
    end
    $display("Tests run %0d, failed %0d, errors %0d", run_tests, fail_tests, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+common
+incdir+test
common/ntm_pkg.sv
common/ntm_mac_if.sv
source/ntm_operand_store.sv
matrix_product/ntm_matrix_product.sv
source/ntm_vector_logistic.sv
source/ntm_input_gate_vector.sv
source/ntm_input_gate_top.sv
test/ntm_input_gate_tb.sv
